// ==== design/core_dmem_port.sv ====
`timescale 1ns/1ps

module core_dmem_port (
    input  logic                                   clk_i,
    input  logic                                   reset_n_i,

    // Core data port
    input  tcu_memmap_pkg::core_req_t              req_i,
    output logic                                   stall_o,
    output logic [tcu_memmap_pkg::CORE_DATA_W-1:0] rdata_o,

    // Data memory
    output tcu_memmap_pkg::line_req_t              dmem_req_o,
    input  logic [tcu_memmap_pkg::LINE_DATA_W-1:0] dmem_rdata_i,
    input  logic                                   dmem_stall_i,

    // Register file of the unit
    output tcu_memmap_pkg::reg_req_t               reg_req_o,
    input  logic [tcu_memmap_pkg::REG_DATA_W-1:0]  reg_rdata_i,
    input  logic                                   reg_stall_i
);

    import tcu_memmap_pkg::*;

    logic       in_win;         // Request hits the register window
    logic       half;           // Upper 32 bits of the register word
    logic       in_win_q;
    logic       half_q;
    core_req_t  steer_req;
    logic [CORE_DATA_W-1:0] line_word;

    assign in_win = (req_i.addr[CORE_ADDR_W-1 -: 4] == REG_WINDOW_NIBBLE);
    assign half   = req_i.addr[2];

    // --------------------------------------
    // Register window

    always_comb begin
        reg_req_o = '0;
        if (in_win) begin
            reg_req_o.en   = req_i.en;
            reg_req_o.addr = {req_i.addr[REG_ADDR_W-1:3], 3'b000};

            reg_req_o.bsel[int'(half)*CORE_BSEL_W +: CORE_BSEL_W]  = req_i.bsel;
            reg_req_o.wdata[int'(half)*CORE_DATA_W +: CORE_DATA_W] = req_i.wdata;
        end
    end

    // --------------------------------------
    // Data memory

    // Outside the window only, so the memory never sees register accesses
    assign steer_req = in_win ? '0 : req_i;

    word_lane_steer dmem_steer (
        .clk_i        (clk_i),
        .reset_n_i    (reset_n_i),
        .req_i        (steer_req),
        .line_req_o   (dmem_req_o),
        .line_rdata_i (dmem_rdata_i),
        .rdata_o      (line_word)
    );

    assign stall_o = (in_win & reg_stall_i) | (~in_win & dmem_stall_i);

    // --------------------------------------
    // Read return

    always_ff @(posedge clk_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            in_win_q <= 1'b0;
            half_q   <= 1'b0;
        end else begin
            in_win_q <= in_win;
            half_q   <= half;
        end
    end

    always_comb begin
        if (in_win_q) begin
            rdata_o = reg_rdata_i[int'(half_q)*CORE_DATA_W +: CORE_DATA_W];
        end else begin
            rdata_o = line_word;    // Lane already picked by the steer
        end
    end

endmodule

// ==== design/tcu_mem_router.sv ====
`timescale 1ns/1ps

module tcu_mem_router (
    input  logic                          clk_i,
    input  logic                          reset_n_i,

    // Unit memory port
    input  tcu_memmap_pkg::tcu_req_t      req_i,
    output tcu_memmap_pkg::tcu_resp_t     resp_o,

    // Memories
    output tcu_memmap_pkg::tcu_line_req_t dmem_req_o,
    output tcu_memmap_pkg::tcu_line_req_t imem_req_o,
    input  tcu_memmap_pkg::tcu_resp_t     dmem_resp_i,
    input  tcu_memmap_pkg::tcu_resp_t     imem_resp_i
);

    import tcu_memmap_pkg::*;

    logic          sel_dmem;
    logic          sel_imem;
    tcu_target_e   tgt;
    tcu_target_e   tgt_q;
    tcu_line_req_t line_req;

    // --------------------------------------
    // Address decode

    // Offset compare, wraps below the start address
    assign sel_dmem = ((req_i.addr - DMEM_START_ADDR) < DMEM_SIZE);
    assign sel_imem = ((req_i.addr - IMEM_START_ADDR) < IMEM_SIZE);

    always_comb begin
        if (sel_dmem) begin
            tgt = TGT_DMEM;     // Data memory wins an overlap
        end else if (sel_imem) begin
            tgt = TGT_IMEM;
        end else begin
            tgt = TGT_NONE;
        end
    end

    // --------------------------------------
    // Request forwarding

    always_comb begin
        line_req.en     = req_i.en;
        line_req.req    = req_i.req;
        line_req.bsel   = req_i.bsel;
        line_req.addr   = req_i.addr[$clog2(LINE_BSEL_W) +: LINE_ADDR_W];
        line_req.wdata  = req_i.wdata;
        line_req.wabort = req_i.wabort;
    end

    always_comb begin
        dmem_req_o = '0;
        imem_req_o = '0;
        if (tgt == TGT_DMEM) begin
            dmem_req_o = line_req;
        end else if (tgt == TGT_IMEM) begin
            imem_req_o = line_req;
        end
    end

    // --------------------------------------
    // Return path

    always_ff @(posedge clk_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            tgt_q <= TGT_NONE;
        end else begin
            tgt_q <= tgt;
        end
    end

    always_comb begin
        resp_o = '0;
        case (tgt_q)
            TGT_DMEM: begin
                resp_o.rdata        = dmem_resp_i.rdata;
                resp_o.rdata_avail  = dmem_resp_i.rdata_avail;
                resp_o.wdata_infifo = dmem_resp_i.wdata_infifo;
            end
            TGT_IMEM: begin
                resp_o.rdata        = imem_resp_i.rdata;
                resp_o.rdata_avail  = imem_resp_i.rdata_avail;
                resp_o.wdata_infifo = imem_resp_i.wdata_infifo;
            end
            default: ;
        endcase

        // Stalls follow the current request, not the registered one
        resp_o.wstall = ((tgt == TGT_DMEM) & dmem_resp_i.wstall) |
                        ((tgt == TGT_IMEM) & imem_resp_i.wstall);
        resp_o.rstall = ((tgt == TGT_DMEM) & dmem_resp_i.rstall) |
                        ((tgt == TGT_IMEM) & imem_resp_i.rstall);
    end

endmodule

// ==== design/tcu_memmap.sv ====
`timescale 1ns/1ps

module tcu_memmap (
    input  logic                                   clk_i,
    input  logic                                   reset_n_i,

    // --------------------------------------
    // Core data port
    input  tcu_memmap_pkg::core_req_t              core_dmem_req_i,
    output logic [tcu_memmap_pkg::CORE_DATA_W-1:0] core_dmem_rdata_o,
    output logic                                   core_dmem_stall_o,

    // --------------------------------------
    // Core instruction port
    input  tcu_memmap_pkg::core_req_t              core_imem_req_i,
    output logic [tcu_memmap_pkg::CORE_DATA_W-1:0] core_imem_rdata_o,
    output logic                                   core_imem_stall_o,

    // --------------------------------------
    // Data memory, core side
    output tcu_memmap_pkg::line_req_t              dmem_req_o,
    input  logic [tcu_memmap_pkg::LINE_DATA_W-1:0] dmem_rdata_i,
    input  logic                                   dmem_stall_i,

    // Instruction memory, core side
    output tcu_memmap_pkg::line_req_t              imem_req_o,
    input  logic [tcu_memmap_pkg::LINE_DATA_W-1:0] imem_rdata_i,
    input  logic                                   imem_stall_i,

    // Register file
    output tcu_memmap_pkg::reg_req_t               reg_req_o,
    input  logic [tcu_memmap_pkg::REG_DATA_W-1:0]  reg_rdata_i,
    input  logic                                   reg_stall_i,

    // --------------------------------------
    // Unit memory port
    input  tcu_memmap_pkg::tcu_req_t               tcu_req_i,
    output tcu_memmap_pkg::tcu_resp_t              tcu_resp_o,

    // Memories, unit side
    output tcu_memmap_pkg::tcu_line_req_t          tcu_dmem_req_o,
    input  tcu_memmap_pkg::tcu_resp_t              tcu_dmem_resp_i,
    output tcu_memmap_pkg::tcu_line_req_t          tcu_imem_req_o,
    input  tcu_memmap_pkg::tcu_resp_t              tcu_imem_resp_i
);

    // Data path with the register window
    core_dmem_port dmem_port (
        .clk_i        (clk_i),
        .reset_n_i    (reset_n_i),
        .req_i        (core_dmem_req_i),
        .stall_o      (core_dmem_stall_o),
        .rdata_o      (core_dmem_rdata_o),
        .dmem_req_o   (dmem_req_o),
        .dmem_rdata_i (dmem_rdata_i),
        .dmem_stall_i (dmem_stall_i),
        .reg_req_o    (reg_req_o),
        .reg_rdata_i  (reg_rdata_i),
        .reg_stall_i  (reg_stall_i)
    );

    // Instruction path has no register mapping
    word_lane_steer imem_steer (
        .clk_i        (clk_i),
        .reset_n_i    (reset_n_i),
        .req_i        (core_imem_req_i),
        .line_req_o   (imem_req_o),
        .line_rdata_i (imem_rdata_i),
        .rdata_o      (core_imem_rdata_o)
    );

    assign core_imem_stall_o = imem_stall_i;   // Single destination

    tcu_mem_router mem_router (
        .clk_i       (clk_i),
        .reset_n_i   (reset_n_i),
        .req_i       (tcu_req_i),
        .resp_o      (tcu_resp_o),
        .dmem_req_o  (tcu_dmem_req_o),
        .imem_req_o  (tcu_imem_req_o),
        .dmem_resp_i (tcu_dmem_resp_i),
        .imem_resp_i (tcu_imem_resp_i)
    );

endmodule

// ==== design/tcu_memmap_pkg.sv ====
package tcu_memmap_pkg;

    // --------------------------------------
    // Widths

    localparam int CORE_DATA_W = 32;
    localparam int CORE_BSEL_W = CORE_DATA_W / 8;
    localparam int CORE_ADDR_W = 32;

    localparam int LINE_DATA_W = 128;
    localparam int LINE_BSEL_W = LINE_DATA_W / 8;
    localparam int LINE_ADDR_W = 14;                // 16-byte lines, 256 KiB per memory

    localparam int REG_DATA_W = 64;
    localparam int REG_BSEL_W = REG_DATA_W / 8;
    localparam int REG_ADDR_W = 16;

    // --------------------------------------
    // Address map

    localparam logic [3:0] REG_WINDOW_NIBBLE = 4'hF;   // Core addr[31:28] of the register window

    localparam logic [CORE_ADDR_W-1:0] DMEM_START_ADDR = 32'h0004_0000;
    localparam logic [CORE_ADDR_W-1:0] DMEM_SIZE       = 32'h0004_0000;
    localparam logic [CORE_ADDR_W-1:0] IMEM_START_ADDR = 32'h0000_0000;
    localparam logic [CORE_ADDR_W-1:0] IMEM_SIZE       = 32'h0004_0000;

    // --------------------------------------
    // Request and response bundles

    // Core side, byte address
    typedef struct packed {
        logic                   en;
        logic [CORE_BSEL_W-1:0] bsel;
        logic [CORE_ADDR_W-1:0] addr;
        logic [CORE_DATA_W-1:0] wdata;
    } core_req_t;

    // Memory side, line address
    typedef struct packed {
        logic                   en;
        logic [LINE_BSEL_W-1:0] bsel;
        logic [LINE_ADDR_W-1:0] addr;
        logic [LINE_DATA_W-1:0] wdata;
    } line_req_t;

    typedef struct packed {
        logic                  en;
        logic [REG_BSEL_W-1:0] bsel;
        logic [REG_ADDR_W-1:0] addr;    // Always 8-byte aligned
        logic [REG_DATA_W-1:0] wdata;
    } reg_req_t;

    // Unit memory port, byte address
    typedef struct packed {
        logic                   en;
        logic                   req;
        logic [LINE_BSEL_W-1:0] bsel;
        logic [CORE_ADDR_W-1:0] addr;
        logic [LINE_DATA_W-1:0] wdata;
        logic                   wabort;
    } tcu_req_t;

    typedef struct packed {
        logic                   en;
        logic                   req;
        logic [LINE_BSEL_W-1:0] bsel;
        logic [LINE_ADDR_W-1:0] addr;
        logic [LINE_DATA_W-1:0] wdata;
        logic                   wabort;
    } tcu_line_req_t;

    typedef struct packed {
        logic [LINE_DATA_W-1:0] rdata;
        logic                   rdata_avail;
        logic                   wdata_infifo;
        logic                   wstall;
        logic                   rstall;
    } tcu_resp_t;

    // Registered return path of the unit router
    typedef enum logic [1:0] {
        TGT_NONE = 2'd0,
        TGT_DMEM = 2'd1,
        TGT_IMEM = 2'd2
    } tcu_target_e;

endpackage

// ==== design/word_lane_steer.sv ====
`timescale 1ns/1ps

module word_lane_steer #(
    parameter int LINE_BYTES = tcu_memmap_pkg::LINE_BSEL_W
)(
    input  logic                                  clk_i,
    input  logic                                  reset_n_i,

    input  tcu_memmap_pkg::core_req_t             req_i,
    output tcu_memmap_pkg::line_req_t             line_req_o,
    input  logic [tcu_memmap_pkg::LINE_DATA_W-1:0] line_rdata_i,
    output logic [tcu_memmap_pkg::CORE_DATA_W-1:0] rdata_o
);

    import tcu_memmap_pkg::*;

    // Byte offset bits inside a line, and word lane bits above the word offset
    localparam int OFFS_W = $clog2(LINE_BYTES);
    localparam int LANE_W = OFFS_W - 2;

    logic [LANE_W-1:0] lane;
    logic [LANE_W-1:0] lane_q;

    assign lane = req_i.addr[OFFS_W-1:2];

    // --------------------------------------
    // Write side

    always_comb begin
        line_req_o      = '0;   // Unused lanes stay zero
        line_req_o.en   = req_i.en;
        line_req_o.addr = req_i.addr[OFFS_W +: LINE_ADDR_W];   // Byte to line address

        line_req_o.bsel[int'(lane)*CORE_BSEL_W +: CORE_BSEL_W]  = req_i.bsel;
        line_req_o.wdata[int'(lane)*CORE_DATA_W +: CORE_DATA_W] = req_i.wdata;
    end

    // --------------------------------------
    // Read side

    // Memory answers one cycle after the request, so the lane is kept
    // for exactly one cycle
    always_ff @(posedge clk_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            lane_q <= '0;
        end else begin
            lane_q <= lane;
        end
    end

    assign rdata_o = line_rdata_i[int'(lane_q)*CORE_DATA_W +: CORE_DATA_W];

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f \
    --top-module tcu_memmap_tb -o sim_tcu_memmap

output=$(./obj_dir/sim_tcu_memmap)
echo "$output"

if grep -qF '*** PASSED ***' <<< "$output"; then
    exit 0
fi
exit 1

// ==== tb/tcu_memmap_tb_util.svh ====
`ifndef TCU_MEMMAP_TB_UTIL_SVH
`define TCU_MEMMAP_TB_UTIL_SVH

localparam logic [31:0] LFSR_SEED = 32'hadf1_ce44;
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;    // x^32 + x^22 + x^2 + x + 1

logic [31:0] lfsr_state  = LFSR_SEED;
int          err_count   = 0;
int          check_count = 0;

// One LFSR step per returned bit
function automatic logic [31:0] take_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
        r = {r[30:0], lfsr_state[0]};
    end
    return r;
endfunction

// --------------------------------------
// Reference steering

function automatic line_req_t exp_line_req(core_req_t req);
    line_req_t r;
    r = '0;
    r.en   = req.en;
    r.addr = req.addr[17:4];
    for (int i = 0; i < 4; i++) begin
        if (req.addr[3:2] == 2'(i)) begin
            r.bsel[i*4 +: 4]    = req.bsel;
            r.wdata[i*32 +: 32] = req.wdata;
        end
    end
    return r;
endfunction

function automatic reg_req_t exp_reg_req(core_req_t req);
    reg_req_t r;
    r = '0;
    if (req.addr[31:28] == REG_WINDOW_NIBBLE) begin
        r.en   = req.en;
        r.addr = {req.addr[15:3], 3'b000};
        if (req.addr[2]) begin
            r.bsel  = {req.bsel, 4'h0};
            r.wdata = {req.wdata, 32'h0};
        end else begin
            r.bsel  = {4'h0, req.bsel};
            r.wdata = {32'h0, req.wdata};
        end
    end
    return r;
endfunction

function automatic tcu_target_e exp_tcu_target(logic [31:0] addr);
    if (addr >= DMEM_START_ADDR && addr < DMEM_START_ADDR + DMEM_SIZE) begin
        return TGT_DMEM;
    end else if (addr >= IMEM_START_ADDR && addr < IMEM_START_ADDR + IMEM_SIZE) begin
        return TGT_IMEM;
    end
    return TGT_NONE;
endfunction

function automatic tcu_line_req_t exp_tcu_line_req(tcu_req_t req);
    tcu_line_req_t r;
    r.en     = req.en;
    r.req    = req.req;
    r.bsel   = req.bsel;
    r.addr   = req.addr[17:4];
    r.wdata  = req.wdata;
    r.wabort = req.wabort;
    return r;
endfunction

// --------------------------------------
// Error reporting

task automatic value_error(string test, logic [191:0] expected, logic [191:0] actual);
    err_count++;
    $display("Fail %s: expected %0h, actual %0h", test, expected, actual);
endtask

task automatic other_error(string msg);
    err_count++;
    $display("Error: %s", msg);
endtask

`endif

// ==== tb/tcu_memmap_tb.sv ====
`timescale 1ns/1ps

module tcu_memmap_tb;

    import tcu_memmap_pkg::*;

    `include "tcu_memmap_tb_util.svh"

    localparam int NUM_CYCLES  = 1200;
    localparam int CYCLE_LIMIT = 2000;

    // One model fill salt per memory
    localparam logic [31:0] SALT_DMEM  = 32'h1d4e_0a37;
    localparam logic [31:0] SALT_IMEM  = 32'h6b20_f591;
    localparam logic [31:0] SALT_REG   = 32'hc3a9_5e08;
    localparam logic [31:0] SALT_TDMEM = 32'h2f87_b4c6;
    localparam logic [31:0] SALT_TIMEM = 32'h9e15_3d72;

    logic          clk_i = 1'b0;
    logic          reset_n_i;
    int            cycle_count = 0;

    core_req_t     core_dmem_req;
    core_req_t     core_imem_req;
    logic [31:0]   core_dmem_rdata;
    logic [31:0]   core_imem_rdata;
    logic          core_dmem_stall;
    logic          core_imem_stall;
    line_req_t     dmem_req;
    line_req_t     imem_req;
    logic [127:0]  dmem_rdata;
    logic [127:0]  imem_rdata;
    logic          dmem_stall;
    logic          imem_stall;
    reg_req_t      reg_req;
    logic [63:0]   reg_rdata;
    logic          reg_stall;
    tcu_req_t      tcu_req;
    tcu_resp_t     tcu_resp;
    tcu_line_req_t tcu_dmem_req;
    tcu_line_req_t tcu_imem_req;
    tcu_resp_t     tcu_dmem_resp;
    tcu_resp_t     tcu_imem_resp;
    logic [3:0]    tcu_dmem_status;     // Avail, infifo, wstall, rstall
    logic [3:0]    tcu_imem_status;

    core_req_t     prev_dmem_req;
    core_req_t     prev_imem_req;
    tcu_req_t      prev_tcu_req;

    logic [LINE_ADDR_W-1:0] dmem_addr_q  = '0;
    logic [LINE_ADDR_W-1:0] imem_addr_q  = '0;
    logic [LINE_ADDR_W-1:0] tdmem_addr_q = '0;
    logic [LINE_ADDR_W-1:0] timem_addr_q = '0;
    logic [REG_ADDR_W-1:0]  reg_addr_q   = '0;

    always #10 clk_i = ~clk_i;

    tcu_memmap dut0 (
        .clk_i             (clk_i),
        .reset_n_i         (reset_n_i),
        .core_dmem_req_i   (core_dmem_req),
        .core_dmem_rdata_o (core_dmem_rdata),
        .core_dmem_stall_o (core_dmem_stall),
        .core_imem_req_i   (core_imem_req),
        .core_imem_rdata_o (core_imem_rdata),
        .core_imem_stall_o (core_imem_stall),
        .dmem_req_o        (dmem_req),
        .dmem_rdata_i      (dmem_rdata),
        .dmem_stall_i      (dmem_stall),
        .imem_req_o        (imem_req),
        .imem_rdata_i      (imem_rdata),
        .imem_stall_i      (imem_stall),
        .reg_req_o         (reg_req),
        .reg_rdata_i       (reg_rdata),
        .reg_stall_i       (reg_stall),
        .tcu_req_i         (tcu_req),
        .tcu_resp_o        (tcu_resp),
        .tcu_dmem_req_o    (tcu_dmem_req),
        .tcu_dmem_resp_i   (tcu_dmem_resp),
        .tcu_imem_req_o    (tcu_imem_req),
        .tcu_imem_resp_i   (tcu_imem_resp)
    );

    // --------------------------------------
    // Memory models return data for the address of the previous cycle

    function automatic logic [31:0] line_word(logic [13:0] addr, logic [1:0] lane,
                                              logic [31:0] salt);
        return salt ^ {addr, lane, addr, lane};
    endfunction

    function automatic logic [127:0] line_pattern(logic [13:0] addr, logic [31:0] salt);
        return {line_word(addr, 2'd3, salt), line_word(addr, 2'd2, salt),
                line_word(addr, 2'd1, salt), line_word(addr, 2'd0, salt)};
    endfunction

    function automatic logic [31:0] reg_word(logic [15:0] addr, logic half, logic [31:0] salt);
        return salt ^ {addr, ~addr[15:1], half};
    endfunction

    always @(posedge clk_i) begin
        dmem_addr_q  <= dmem_req.addr;
        imem_addr_q  <= imem_req.addr;
        reg_addr_q   <= reg_req.addr;
        tdmem_addr_q <= tcu_dmem_req.addr;
        timem_addr_q <= tcu_imem_req.addr;
    end

    assign dmem_rdata    = line_pattern(dmem_addr_q, SALT_DMEM);
    assign imem_rdata    = line_pattern(imem_addr_q, SALT_IMEM);
    assign reg_rdata     = {reg_word(reg_addr_q, 1'b1, SALT_REG),
                            reg_word(reg_addr_q, 1'b0, SALT_REG)};
    assign tcu_dmem_resp = {line_pattern(tdmem_addr_q, SALT_TDMEM), tcu_dmem_status};
    assign tcu_imem_resp = {line_pattern(timem_addr_q, SALT_TIMEM), tcu_imem_status};

    // --------------------------------------
    // Stimulus

    task automatic drive_zero();
        core_dmem_req   = '0;
        core_imem_req   = '0;
        tcu_req         = '0;
        dmem_stall      = 1'b0;
        imem_stall      = 1'b0;
        reg_stall       = 1'b0;
        tcu_dmem_status = 4'h0;
        tcu_imem_status = 4'h0;
        prev_dmem_req   = '0;
        prev_imem_req   = '0;
        prev_tcu_req    = '0;
    endtask

    task automatic drive_random();
        logic [2:0] pick;
        prev_dmem_req = core_dmem_req;
        prev_imem_req = core_imem_req;
        prev_tcu_req  = tcu_req;
        pick = 3'(take_bits(3));
        if (pick != 3'd0) begin     // Zero holds the request, as under a stall
            core_dmem_req.en    = 1'(take_bits(1));
            core_dmem_req.bsel  = 4'(take_bits(4));
            core_dmem_req.addr  = take_bits(32);
            core_dmem_req.wdata = take_bits(32);
            if (pick < 3'd3) begin
                core_dmem_req.addr[31:28] = REG_WINDOW_NIBBLE;
            end else if (core_dmem_req.addr[31:28] == REG_WINDOW_NIBBLE) begin
                core_dmem_req.addr[31] = 1'b0;
            end
        end
        core_imem_req.en    = 1'(take_bits(1));
        core_imem_req.bsel  = 4'(take_bits(4));
        core_imem_req.addr  = take_bits(32);
        core_imem_req.wdata = take_bits(32);
        tcu_req.en     = 1'(take_bits(1));
        tcu_req.req    = 1'(take_bits(1));
        tcu_req.bsel   = 16'(take_bits(16));
        tcu_req.wabort = 1'(take_bits(1));
        for (int i = 0; i < 4; i++) begin
            tcu_req.wdata[i*32 +: 32] = take_bits(32);
        end
        case (2'(take_bits(2)))
            2'd0:    tcu_req.addr = {13'd0, 1'b1, 18'(take_bits(18))};   // Data memory range
            2'd1:    tcu_req.addr = {14'd0, 18'(take_bits(18))};
            2'd2:    tcu_req.addr = 32'h0007_ffe0 + 32'(take_bits(6));   // Upper range edge
            default: tcu_req.addr = take_bits(32);
        endcase
        dmem_stall      = 1'(take_bits(1));
        imem_stall      = 1'(take_bits(1));
        reg_stall       = 1'(take_bits(1));
        tcu_dmem_status = 4'(take_bits(4));
        tcu_imem_status = 4'(take_bits(4));
    endtask

    // --------------------------------------
    // Checks

    task automatic check_reset();
        check_count += 2;
        assert (!dmem_req.en && !imem_req.en && !reg_req.en && !tcu_dmem_req.en
                && !tcu_imem_req.en)
            else other_error("an enable output is set during reset");
        assert (tcu_resp == '0) else value_error("reset response", 192'(0), 192'(tcu_resp));
    endtask

    task automatic check_core_data();
        logic        in_win;
        line_req_t   exp_line;
        reg_req_t    exp_reg;
        logic        exp_stall;
        logic [31:0] exp_word;
        in_win    = (core_dmem_req.addr[31:28] == REG_WINDOW_NIBBLE);
        exp_line  = in_win ? '0 : exp_line_req(core_dmem_req);
        exp_reg   = exp_reg_req(core_dmem_req);
        exp_stall = in_win ? reg_stall : dmem_stall;
        if (prev_dmem_req.addr[31:28] == REG_WINDOW_NIBBLE) begin
            exp_word = reg_word({prev_dmem_req.addr[15:3], 3'b000}, prev_dmem_req.addr[2],
                                SALT_REG);
        end else begin
            exp_word = line_word(prev_dmem_req.addr[17:4], prev_dmem_req.addr[3:2], SALT_DMEM);
        end
        check_count += 4;
        assert (dmem_req == exp_line)
            else value_error("core data steering", 192'(exp_line), 192'(dmem_req));
        assert (reg_req == exp_reg)
            else value_error("register window", 192'(exp_reg), 192'(reg_req));
        assert (core_dmem_stall == exp_stall)
            else value_error("core data stall", 192'(exp_stall), 192'(core_dmem_stall));
        assert (core_dmem_rdata == exp_word)
            else value_error("core data read", 192'(exp_word), 192'(core_dmem_rdata));
    endtask

    task automatic check_instr();
        line_req_t   exp_line;
        logic [31:0] exp_word;
        exp_line = exp_line_req(core_imem_req);
        exp_word = line_word(prev_imem_req.addr[17:4], prev_imem_req.addr[3:2], SALT_IMEM);
        check_count += 3;
        assert (imem_req == exp_line)
            else value_error("instruction steering", 192'(exp_line), 192'(imem_req));
        assert (core_imem_stall == imem_stall)
            else value_error("instruction stall", 192'(imem_stall), 192'(core_imem_stall));
        assert (core_imem_rdata == exp_word)
            else value_error("instruction read", 192'(exp_word), 192'(core_imem_rdata));
    endtask

    task automatic check_unit();
        tcu_target_e   tgt;
        tcu_target_e   tgt_prev;
        tcu_line_req_t exp_d;
        tcu_line_req_t exp_i;
        tcu_resp_t     exp_resp;
        tgt      = exp_tcu_target(tcu_req.addr);
        tgt_prev = exp_tcu_target(prev_tcu_req.addr);
        exp_d    = (tgt == TGT_DMEM) ? exp_tcu_line_req(tcu_req) : '0;
        exp_i    = (tgt == TGT_IMEM) ? exp_tcu_line_req(tcu_req) : '0;
        exp_resp = '0;
        if (tgt_prev == TGT_DMEM) begin
            exp_resp.rdata = line_pattern(prev_tcu_req.addr[17:4], SALT_TDMEM);
            {exp_resp.rdata_avail, exp_resp.wdata_infifo} = tcu_dmem_status[3:2];
        end else if (tgt_prev == TGT_IMEM) begin
            exp_resp.rdata = line_pattern(prev_tcu_req.addr[17:4], SALT_TIMEM);
            {exp_resp.rdata_avail, exp_resp.wdata_infifo} = tcu_imem_status[3:2];
        end
        if (tgt == TGT_DMEM) begin
            {exp_resp.wstall, exp_resp.rstall} = tcu_dmem_status[1:0];
        end else if (tgt == TGT_IMEM) begin
            {exp_resp.wstall, exp_resp.rstall} = tcu_imem_status[1:0];
        end
        check_count += 3;
        assert (tcu_dmem_req == exp_d)
            else value_error("unit to data memory", 192'(exp_d), 192'(tcu_dmem_req));
        assert (tcu_imem_req == exp_i)
            else value_error("unit to instruction memory", 192'(exp_i), 192'(tcu_imem_req));
        assert (tcu_resp == exp_resp)
            else value_error("unit response", 192'(exp_resp), 192'(tcu_resp));
    endtask

    // --------------------------------------
    // Sequence and watchdog

    initial begin
        reset_n_i = 1'b0;
        drive_zero();
        repeat (4) begin
            @(posedge clk_i);
            #12;
            check_reset();
        end
        @(posedge clk_i);
        #2;
        reset_n_i = 1'b1;
        repeat (NUM_CYCLES) begin
            @(posedge clk_i);
            #2;
            drive_random();
            #10;        // Combinational paths have settled well before the next edge
            check_core_data();
            check_instr();
            check_unit();
        end
        @(posedge clk_i);
        $display("Checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the test sequence did not finish", cycle_count);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+tb
design/tcu_memmap_pkg.sv
design/word_lane_steer.sv
design/core_dmem_port.sv
design/tcu_mem_router.sv
design/tcu_memmap.sv
tb/tcu_memmap_tb.sv
